// File: nexysAdderPkg.sv
package nexysAdderPkg;

  // **************************************************
  // Datapath widths
  // **************************************************

  // Adder operands and sum.
  typedef logic [31:0] word_t;

  // One hex digit of the display.
  typedef logic [3:0] nibble_t;

  // **************************************************
  // Display widths
  // **************************************************

  // Index of the digit being scanned, 0 to 7.
  typedef logic [2:0] digitSel_t;

  // Active-low segments, CA in the top bit down to CG.
  typedef logic [6:0] segments_t;

  // Active-low digit enables, one per digit.
  typedef logic [7:0] anodes_t;

  // Digits on the board.
  localparam int numDigits = 8;

endpackage

// File: operandAdder.sv
module operandAdder import nexysAdderPkg::*; (
  input  logic  CLK100,
  input  logic  resetn,
  input  word_t opA,
  input  word_t opB,
  input  logic  carryIn,
  output word_t sum
);

  localparam int wordWidth = $bits(word_t);

  // Carry into each bit position.
  logic [wordWidth-1:0] carry;
  word_t                sumComb;

  // **************************************************
  // Ripple-carry chain
  // **************************************************

  assign carry[0] = carryIn;

  for (genvar i = 0; i < wordWidth; i++) begin : gFullAdder
    logic halfSum;

    assign halfSum    = opA[i] ^ opB[i];
    assign sumComb[i] = halfSum ^ carry[i];

    // Last stage has no carry out.
    if (i < wordWidth - 1) begin : gCarry
      assign carry[i+1] = (opA[i] & opB[i]) | (carry[i] & halfSum);
    end
  end

  // **************************************************
  // Sum register
  // **************************************************

  always_ff @(posedge CLK100) begin
    if (!resetn) begin
      sum <= '0;
    end else begin
      sum <= sumComb; // One cycle after the operands.
    end
  end

endmodule

// File: digitScanner.sv
module digitScanner import nexysAdderPkg::*; #(
  parameter int scanPeriod = 1000
) (
  input  logic      CLK100,
  input  logic      resetn,
  output digitSel_t digitSel
);

  // At least one bit, even for a period of one.
  localparam int cntWidth = (scanPeriod > 1) ? $clog2(scanPeriod) : 1;

  localparam logic [cntWidth-1:0] lastCount = cntWidth'(scanPeriod - 1);
  localparam digitSel_t           lastDigit = digitSel_t'(numDigits - 1);

  logic [cntWidth-1:0] periodCnt;
  logic                periodWrap;

  assign periodWrap = (periodCnt == lastCount);

  // **************************************************
  // Period counter
  // **************************************************

  always_ff @(posedge CLK100) begin
    if (!resetn) begin
      periodCnt <= '0;
    end else if (periodWrap) begin
      periodCnt <= '0;
    end else begin
      periodCnt <= periodCnt + 1'b1;
    end
  end

  // **************************************************
  // Digit index
  // **************************************************

  always_ff @(posedge CLK100) begin
    if (!resetn) begin
      digitSel <= '0;
    end else if (periodWrap) begin
      if (digitSel == lastDigit) begin
        digitSel <= '0; // Back to the rightmost digit.
      end else begin
        digitSel <= digitSel + 1'b1;
      end
    end
  end

endmodule

// File: segmentDriver.sv
module segmentDriver import nexysAdderPkg::*; (
  input  logic      CLK100,
  input  logic      resetn,
  input  digitSel_t digitSel,
  input  word_t     sum,
  input  word_t     opA,
  input  word_t     opB,
  output anodes_t   AN,
  output logic      CA,
  output logic      CB,
  output logic      CC,
  output logic      CD,
  output logic      CE,
  output logic      CF,
  output logic      CG,
  output logic      DP
);

  // Decimal point between A and B.
  localparam digitSel_t pointDigit = 3'd6;

  nibble_t   nibble;
  segments_t segNext;
  anodes_t   anNext;

  anodes_t   anReg;
  segments_t segReg;
  logic      dpReg;

  // **************************************************
  // Hex to seven segments
  // **************************************************

  // Active low, CA first.
  function automatic segments_t hexToSegments(input nibble_t value);
    segments_t seg;

    case (value)
      4'h0: seg = 7'b0000001;
      4'h1: seg = 7'b1001111;
      4'h2: seg = 7'b0010010;
      4'h3: seg = 7'b0000110;
      4'h4: seg = 7'b1001100;
      4'h5: seg = 7'b0100100;
      4'h6: seg = 7'b0100000;
      4'h7: seg = 7'b0001111;
      4'h8: seg = 7'b0000000;
      4'h9: seg = 7'b0000100;
      4'hA: seg = 7'b0001000;
      4'hB: seg = 7'b1100000;
      4'hC: seg = 7'b0110001;
      4'hD: seg = 7'b1000010;
      4'hE: seg = 7'b0110000;
      default: seg = 7'b0111000; // F.
    endcase
    return seg;
  endfunction

  // **************************************************
  // Nibble select
  // **************************************************

  always_comb begin
    case (digitSel)
      3'd0: nibble = sum[3:0];
      3'd1: nibble = sum[7:4];
      3'd2: nibble = sum[11:8];
      3'd3: nibble = sum[15:12];
      3'd4: nibble = opB[3:0];   // Operand B.
      3'd5: nibble = opB[7:4];
      3'd6: nibble = opA[3:0];   // Operand A.
      3'd7: nibble = opA[7:4];
    endcase
  end

  assign segNext = hexToSegments(nibble);

  // One zero at the scanned digit.
  assign anNext = ~(anodes_t'(1) << digitSel);

  // **************************************************
  // Output registers
  // **************************************************

  always_ff @(posedge CLK100) begin
    if (!resetn) begin
      anReg  <= '1; // All digits off.
      segReg <= '1;
      dpReg  <= 1'b1;
    end else begin
      anReg  <= anNext;
      segReg <= segNext;
      dpReg  <= (digitSel != pointDigit);
    end
  end

  assign AN = anReg;
  assign {CA, CB, CC, CD, CE, CF, CG} = segReg;
  assign DP = dpReg;

endmodule

// File: nexysAdder.sv
module nexysAdder import nexysAdderPkg::*; #(
  parameter int scanPeriod = 1000
) (
  input  logic        CLK100,
  input  logic        resetn,
  input  logic        BTND,
  input  logic [15:0] SW,
  output logic [15:0] LED,
  output logic        CA,
  output logic        CB,
  output logic        CC,
  output logic        CD,
  output logic        CE,
  output logic        CF,
  output logic        CG,
  output logic        DP,
  output logic [7:0]  AN
);

  word_t     opA;
  word_t     opB;
  word_t     sum;
  digitSel_t digitSel;

  // Switches zero-extended to full words.
  assign opA = {24'b0, SW[15:8]};
  assign opB = {24'b0, SW[7:0]};

  assign LED = sum[15:0]; // Low half of the sum.

  // **************************************************
  // Adder
  // **************************************************

  operandAdder operandAdder_inst (
    .CLK100  (CLK100),
    .resetn  (resetn),
    .opA     (opA),
    .opB     (opB),
    .carryIn (BTND),
    .sum     (sum)
  );

  // **************************************************
  // Display
  // **************************************************

  digitScanner #(
    .scanPeriod (scanPeriod)
  ) digitScanner_inst (
    .CLK100   (CLK100),
    .resetn   (resetn),
    .digitSel (digitSel)
  );

  segmentDriver segmentDriver_inst (
    .CLK100   (CLK100),
    .resetn   (resetn),
    .digitSel (digitSel),
    .sum      (sum),
    .opA      (opA),
    .opB      (opB),
    .AN       (AN),
    .CA       (CA),
    .CB       (CB),
    .CC       (CC),
    .CD       (CD),
    .CE       (CE),
    .CF       (CF),
    .CG       (CG),
    .DP       (DP)
  );

endmodule

// File: tbClock.sv
module tbClock (
  output logic CLK100,
  output logic resetn
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int halfPeriod  = 20; // 40 ns period.
  localparam int resetCycles = 16;

  initial CLK100 = 1'b0;

  always #(halfPeriod) CLK100 = ~CLK100;

  // Release on a falling edge, like every other input.
  initial begin
    resetn = 1'b0;
    repeat (resetCycles) @(posedge CLK100);
    @(negedge CLK100);
    resetn = 1'b1;
  end

endmodule

// File: tbNexysAdder.sv
module tbNexysAdder import nexysAdderPkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int scanPeriod = 4;
  localparam int maxRound   = numDigits * scanPeriod + 2; // Full round plus pipeline.
  localparam int waitLimit  = 200;

  logic        CLK100;
  logic        resetn;
  logic        BTND;
  logic [15:0] SW;
  logic [15:0] LED;
  logic        CA;
  logic        CB;
  logic        CC;
  logic        CD;
  logic        CE;
  logic        CF;
  logic        CG;
  logic        DP;
  anodes_t     AN;

  logic        scanActive;
  int          sinceSeen [numDigits];
  int          vectorCount;

  tbClock tbClock_inst (
    .CLK100 (CLK100),
    .resetn (resetn)
  );

  nexysAdder #(
    .scanPeriod (scanPeriod)
  ) nexysAdder_inst (
    .CLK100 (CLK100),
    .resetn (resetn),
    .BTND   (BTND),
    .SW     (SW),
    .LED    (LED),
    .CA     (CA),
    .CB     (CB),
    .CC     (CC),
    .CD     (CD),
    .CE     (CE),
    .CF     (CF),
    .CG     (CG),
    .DP     (DP),
    .AN     (AN)
  );

  // **************************************************
  // Checking helpers
  // **************************************************

  task automatic stopOnFailure();
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic checkValue(input logic [63:0] actual, input logic [63:0] expected,
                            input string what);
    if (actual !== expected) begin
      $display("Fail at %0d ns: %s, expected %0h, got %0h", $time, what, expected, actual);
      stopOnFailure();
    end
  endtask

  task automatic checkResetState();
    checkValue(64'(AN), 64'hFF, "AN during reset");
    checkValue(64'({DP, CA, CB, CC, CD, CE, CF, CG}), 64'hFF, "segments during reset");
    checkValue(64'(LED), 64'h0, "LED during reset");
  endtask

  // Outputs stay dark until the first edge with resetn high.
  task automatic waitReset();
    int cycles;
    bit released;

    cycles   = 0;
    released = 1'b0;
    @(posedge CLK100);
    while (!released && cycles < waitLimit) begin
      @(negedge CLK100);
      checkResetState();
      @(posedge CLK100);
      released = resetn;
      cycles++;
    end
    if (!released) begin
      $display("Reset was never released within %0d cycles", waitLimit);
      stopOnFailure();
    end
  endtask

  task automatic waitForDigit(input int digit);
    int      cycles;
    anodes_t wanted;

    wanted = ~(anodes_t'(1) << digit);
    cycles = 0;
    while (AN !== wanted && cycles < waitLimit) begin
      @(negedge CLK100);
      cycles++;
    end
    if (AN !== wanted) begin
      $display("Digit %0d never appeared on AN within %0d cycles", digit, waitLimit);
      stopOnFailure();
    end
  endtask

  // **************************************************
  // One vector
  // **************************************************

  task automatic applyVector(input logic [15:0] swIn, input logic btnIn,
                             input logic [15:0] ledExp, input logic [63:0] segExp);
    logic [15:0] sumModel;

    sumModel = 16'(swIn[15:8]) + 16'(swIn[7:0]) + 16'(btnIn);
    @(negedge CLK100);
    SW   = swIn;
    BTND = btnIn;
    repeat (2) @(negedge CLK100);
    checkValue(64'(ledExp), 64'(sumModel), "data file sum against operands");
    checkValue(64'(LED), 64'(ledExp), "LED sum");
    @(negedge CLK100); // Display registers hold the new data now.
    for (int d = 0; d < numDigits; d++) begin
      waitForDigit(d);
      checkValue(64'({DP, CA, CB, CC, CD, CE, CF, CG}), 64'(segExp[d*8 +: 8]),
                 $sformatf("digit %0d segments", d));
    end
  endtask

  // **************************************************
  // Scan monitor
  // **************************************************

  always @(negedge CLK100) begin
    if (scanActive) begin
      checkValue(64'(numDigits - $countones(AN)), 64'd1, "digits on at once");
      for (int d = 0; d < numDigits; d++) begin
        if (AN[d] == 1'b0) begin
          sinceSeen[d] = 0;
        end else begin
          sinceSeen[d] = sinceSeen[d] + 1;
        end
        if (sinceSeen[d] > maxRound) begin
          $display("Digit %0d was not scanned within %0d cycles", d, maxRound);
          stopOnFailure();
        end
      end
    end
  end

  // **************************************************
  // Main sequence
  // **************************************************

  initial begin
    int          fd;
    string       line;
    int          fields;
    logic [15:0] vecSw;
    logic        vecBtn;
    logic [15:0] vecLed;
    logic [63:0] vecSeg;

    SW          = '0;
    BTND        = 1'b0;
    scanActive  = 1'b0;
    vectorCount = 0;
    foreach (sinceSeen[d]) begin
      sinceSeen[d] = 0;
    end

    fd = $fopen("nexysAdder_testdata.txt", "r");
    if (fd == 0) begin
      $display("Cannot open nexysAdder_testdata.txt for reading");
      stopOnFailure();
    end

    waitReset();
    scanActive = 1'b1;

    // Comment and blank lines do not scan as four fields.
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      fields = $sscanf(line, "%h %h %h %h", vecSw, vecBtn, vecLed, vecSeg);
      if (fields == 4) begin
        applyVector(vecSw, vecBtn, vecLed, vecSeg);
        vectorCount++;
      end
    end
    $fclose(fd);

    if (vectorCount == 0) begin
      $display("The data file holds no vectors");
      stopOnFailure();
    end else begin
      $display("SIMULATION PASSED");
      $finish;
    end
  end

endmodule

// File: nexysAdder_testdata.txt
# Columns: SW (hex), BTND, expected LED (hex), expected segment bytes
# Bytes are {DP, CA..CG} for digits 7 down to 0, active low.
0000 0 0000 8101818181818181
FFFF 1 01FF B838B8B881CFB8B8
FF00 1 0100 B838818181CF8181
0123 0 0024 814F9286818192CC
4567 0 00AC CC24A08F818188B1
89AB 0 0134 800488E081CF86CC
CDEF 1 01BD B142B0B881CFE0C2
FF01 0 0100 B83881CF81CF8181
0000 1 0001 81018181818181CF
7F80 1 0100 8F38808181CF8181
00FF 0 00FF 8101B8B88181B8B8
8080 0 0100 8001808181CF8181
3A5C 0 0096 8608A4B1818184A0
D21E 1 00F1 C212CFB08181B8CF
6B94 0 00FF A06084CC8181B8B8
E7C3 1 01AB B00FB18681CF88E0
1F58 0 0077 CF38A48081818F8F
A4D9 1 017E 884CC28481CF8FB0
5062 0 00B2 A401A0928181E092
92F6 1 0189 8412B8A081CF8084
0000 0 0000 8101818181818181

// File: project.f
nexysAdderPkg.sv
operandAdder.sv
digitScanner.sv
segmentDriver.sv
nexysAdder.sv
tbClock.sv
tbNexysAdder.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tbNexysAdder -f project.f -o simNexysAdder \
  || { echo "Build failed"; exit 1; }

./obj_dir/simNexysAdder 2>&1 | tee /dev/stderr | grep "SIMULATION PASSED" > /dev/null \
  && { echo "Run result: pass"; exit 0; } \
  || { echo "Run result: fail"; exit 1; }
